//--- rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [6:0]  op_t;
   typedef logic [8:0]  flags_t;
   typedef logic [2:0]  lat_class_t;
   typedef logic [3:0]  count_t;

   // operation ids
   localparam op_t OP_ILLEGAL = 7'd0;
   localparam op_t OP_LUI     = 7'd1;
   localparam op_t OP_AUIPC   = 7'd2;
   localparam op_t OP_JAL     = 7'd3;
   localparam op_t OP_JALR    = 7'd4;
   localparam op_t OP_BEQ     = 7'd5;
   localparam op_t OP_BNE     = 7'd6;
   localparam op_t OP_BLT     = 7'd7;
   localparam op_t OP_BGE     = 7'd8;
   localparam op_t OP_BLTU    = 7'd9;
   localparam op_t OP_BGEU    = 7'd10;
   localparam op_t OP_LB      = 7'd11;
   localparam op_t OP_LH      = 7'd12;
   localparam op_t OP_LW      = 7'd13;
   localparam op_t OP_LBU     = 7'd14;
   localparam op_t OP_LHU     = 7'd15;
   localparam op_t OP_SB      = 7'd16;
   localparam op_t OP_SH      = 7'd17;
   localparam op_t OP_SW      = 7'd18;
   localparam op_t OP_ADDI    = 7'd19;
   localparam op_t OP_SLTI    = 7'd20;
   localparam op_t OP_SLTIU   = 7'd21;
   localparam op_t OP_XORI    = 7'd22;
   localparam op_t OP_ORI     = 7'd23;
   localparam op_t OP_ANDI    = 7'd24;
   localparam op_t OP_SLLI    = 7'd25;
   localparam op_t OP_SRLI    = 7'd26;
   localparam op_t OP_SRAI    = 7'd27;
   localparam op_t OP_ADD     = 7'd28;
   localparam op_t OP_SUB     = 7'd29;
   localparam op_t OP_SLL     = 7'd30;
   localparam op_t OP_SLT     = 7'd31;
   localparam op_t OP_SLTU    = 7'd32;
   localparam op_t OP_XOR     = 7'd33;
   localparam op_t OP_SRL     = 7'd34;
   localparam op_t OP_SRA     = 7'd35;
   localparam op_t OP_OR      = 7'd36;
   localparam op_t OP_AND     = 7'd37;
   // rv32m
   localparam op_t OP_MUL     = 7'd38;
   localparam op_t OP_MULH    = 7'd39;
   localparam op_t OP_MULHSU  = 7'd40;
   localparam op_t OP_MULHU   = 7'd41;
   localparam op_t OP_DIV     = 7'd42;
   localparam op_t OP_DIVU    = 7'd43;
   localparam op_t OP_REM     = 7'd44;
   localparam op_t OP_REMU    = 7'd45;
   // rv32f subset
   localparam op_t OP_FLW     = 7'd46;
   localparam op_t OP_FSW     = 7'd47;
   localparam op_t OP_FADD    = 7'd48;
   localparam op_t OP_FSUB    = 7'd49;
   localparam op_t OP_FMUL    = 7'd50;
   localparam op_t OP_FDIV    = 7'd51;
   localparam op_t OP_FSQRT   = 7'd52;
   localparam op_t OP_FSGNJ   = 7'd53;
   localparam op_t OP_FSGNJN  = 7'd54;
   localparam op_t OP_FSGNJX  = 7'd55;
   localparam op_t OP_FCVTWS  = 7'd56;
   localparam op_t OP_FMVXW   = 7'd57;
   localparam op_t OP_FEQ     = 7'd58;
   localparam op_t OP_FLE     = 7'd59;
   localparam op_t OP_FCVTSW  = 7'd60;
   localparam op_t OP_FMVWX   = 7'd61;

   // bit positions in flags_t
   localparam int FLAG_RV32F          = 0;
   localparam int FLAG_WRITES_REG     = 1;
   localparam int FLAG_WRITES_FREG    = 2;
   localparam int FLAG_USES_REG       = 3;
   localparam int FLAG_USES_FREG      = 4;
   localparam int FLAG_IS_LOAD        = 5;
   localparam int FLAG_IS_STORE       = 6;
   localparam int FLAG_IS_COND_JUMP   = 7;
   localparam int FLAG_JUMP_PREDICTED = 8;

   localparam lat_class_t LAT_CLASS_ALU  = 3'd0;
   localparam lat_class_t LAT_CLASS_LOAD = 3'd1;
   localparam lat_class_t LAT_CLASS_MUL  = 3'd2;
   localparam lat_class_t LAT_CLASS_DIV  = 3'd3;
   localparam lat_class_t LAT_CLASS_FP   = 3'd4;

   typedef enum logic [0:0] {
      S_IDLE,
      S_CHECK
   } ctrl_state_t;

endpackage

`default_nettype wire

//--- rtl/rv_decoder.sv
`default_nettype none

module rv_decoder (
   input  wire                 clk,
   input  wire                 rstn,
   input  wire                 enabled,
   input  wire rv_pkg::word_t  instr_raw,
   input  wire rv_pkg::word_t  pc,
   input  wire                 is_jump_predicted,
   output logic                completed,
   output rv_pkg::op_t         op,
   output rv_pkg::flags_t      flags,
   output rv_pkg::reg_idx_t    rd,
   output rv_pkg::reg_idx_t    rs1,
   output rv_pkg::reg_idx_t    rs2,
   output rv_pkg::word_t       imm,
   output rv_pkg::word_t       pc_out,
   output rv_pkg::lat_class_t  lat_class
);
   import rv_pkg::*;

   logic [6:0] funct7;
   logic [2:0] funct3;
   logic [6:0] opcode;
   reg_idx_t   f_rs2;
   reg_idx_t   f_rs1;
   reg_idx_t   f_rd;

   logic r_type;
   logic i_type;
   logic s_type;
   logic b_type;
   logic u_type;
   logic j_type;

   op_t        op_d;
   flags_t     flags_d;
   lat_class_t lat_d;
   word_t      imm_d;
   logic       done;

   assign funct7 = instr_raw[31:25];
   assign f_rs2  = instr_raw[24:20];
   assign f_rs1  = instr_raw[19:15];
   assign funct3 = instr_raw[14:12];
   assign f_rd   = instr_raw[11:7];
   assign opcode = instr_raw[6:0];

   assign r_type = (opcode == 7'b0110011) || (opcode == 7'b1010011);
   assign i_type = (opcode == 7'b1100111) || (opcode == 7'b0000011)
                || (opcode == 7'b0010011) || (opcode == 7'b0000111);
   assign s_type = (opcode == 7'b0100011) || (opcode == 7'b0100111);
   assign b_type = (opcode == 7'b1100011);
   assign u_type = (opcode == 7'b0110111) || (opcode == 7'b0010111);
   assign j_type = (opcode == 7'b1101111);

   always_comb begin
      op_d = OP_ILLEGAL;
      case (opcode)
         7'b0110111: op_d = OP_LUI;
         7'b0010111: op_d = OP_AUIPC;
         7'b1101111: op_d = OP_JAL;
         7'b1100111: op_d = OP_JALR;
         7'b1100011: begin
            case (funct3)
               3'b000: op_d = OP_BEQ;
               3'b001: op_d = OP_BNE;
               3'b100: op_d = OP_BLT;
               3'b101: op_d = OP_BGE;
               3'b110: op_d = OP_BLTU;
               3'b111: op_d = OP_BGEU;
               default: op_d = OP_ILLEGAL;
            endcase
         end
         7'b0000011: begin
            case (funct3)
               3'b000: op_d = OP_LB;
               3'b001: op_d = OP_LH;
               3'b010: op_d = OP_LW;
               3'b100: op_d = OP_LBU;
               3'b101: op_d = OP_LHU;
               default: op_d = OP_ILLEGAL;
            endcase
         end
         7'b0100011: begin
            case (funct3)
               3'b000: op_d = OP_SB;
               3'b001: op_d = OP_SH;
               3'b010: op_d = OP_SW;
               default: op_d = OP_ILLEGAL;
            endcase
         end
         7'b0010011: begin
            case (funct3)
               3'b000: op_d = OP_ADDI;
               3'b010: op_d = OP_SLTI;
               3'b011: op_d = OP_SLTIU;
               3'b100: op_d = OP_XORI;
               3'b110: op_d = OP_ORI;
               3'b111: op_d = OP_ANDI;
               3'b001: op_d = OP_SLLI;
               default: begin
                  if (funct7 == 7'b0000000)
                     op_d = OP_SRLI;
                  else if (funct7 == 7'b0100000)
                     op_d = OP_SRAI;
               end
            endcase
         end
         7'b0110011: begin
            case ({funct7, funct3})
               {7'b0000000, 3'b000}: op_d = OP_ADD;
               {7'b0100000, 3'b000}: op_d = OP_SUB;
               {7'b0000000, 3'b001}: op_d = OP_SLL;
               {7'b0000000, 3'b010}: op_d = OP_SLT;
               {7'b0000000, 3'b011}: op_d = OP_SLTU;
               {7'b0000000, 3'b100}: op_d = OP_XOR;
               {7'b0000000, 3'b101}: op_d = OP_SRL;
               {7'b0100000, 3'b101}: op_d = OP_SRA;
               {7'b0000000, 3'b110}: op_d = OP_OR;
               {7'b0000000, 3'b111}: op_d = OP_AND;
               {7'b0000001, 3'b000}: op_d = OP_MUL;
               {7'b0000001, 3'b001}: op_d = OP_MULH;
               {7'b0000001, 3'b010}: op_d = OP_MULHSU;
               {7'b0000001, 3'b011}: op_d = OP_MULHU;
               {7'b0000001, 3'b100}: op_d = OP_DIV;
               {7'b0000001, 3'b101}: op_d = OP_DIVU;
               {7'b0000001, 3'b110}: op_d = OP_REM;
               {7'b0000001, 3'b111}: op_d = OP_REMU;
               default: op_d = OP_ILLEGAL;
            endcase
         end
         7'b0000111: if (funct3 == 3'b010) op_d = OP_FLW;
         7'b0100111: if (funct3 == 3'b010) op_d = OP_FSW;
         7'b1010011: begin
            // unary ops need rs2 == 0
            case ({funct7, funct3})
               {7'b0000000, 3'b000}: op_d = OP_FADD;
               {7'b0000100, 3'b000}: op_d = OP_FSUB;
               {7'b0001000, 3'b000}: op_d = OP_FMUL;
               {7'b0001100, 3'b000}: op_d = OP_FDIV;
               {7'b0101100, 3'b000}: if (f_rs2 == '0) op_d = OP_FSQRT;
               {7'b0010000, 3'b000}: op_d = OP_FSGNJ;
               {7'b0010000, 3'b001}: op_d = OP_FSGNJN;
               {7'b0010000, 3'b010}: op_d = OP_FSGNJX;
               {7'b1100000, 3'b000}: if (f_rs2 == '0) op_d = OP_FCVTWS;
               {7'b1110000, 3'b000}: if (f_rs2 == '0) op_d = OP_FMVXW;
               {7'b1010000, 3'b010}: op_d = OP_FEQ;
               {7'b1010000, 3'b000}: op_d = OP_FLE;
               {7'b1101000, 3'b000}: if (f_rs2 == '0) op_d = OP_FCVTSW;
               {7'b1111000, 3'b000}: if (f_rs2 == '0) op_d = OP_FMVWX;
               default: op_d = OP_ILLEGAL;
            endcase
         end
         default: op_d = OP_ILLEGAL;
      endcase
   end

   // start from a plain integer op, then adjust per group
   always_comb begin
      flags_d = '0;
      lat_d = LAT_CLASS_ALU;
      flags_d[FLAG_WRITES_REG] = (op_d != OP_ILLEGAL);
      flags_d[FLAG_USES_REG] = (op_d != OP_ILLEGAL);
      flags_d[FLAG_JUMP_PREDICTED] = is_jump_predicted;
      case (op_d)
         OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
            flags_d[FLAG_IS_COND_JUMP] = 1'b1;
            flags_d[FLAG_WRITES_REG] = 1'b0;
         end
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
            flags_d[FLAG_IS_LOAD] = 1'b1;
            lat_d = LAT_CLASS_LOAD;
         end
         OP_SB, OP_SH, OP_SW: begin
            flags_d[FLAG_IS_STORE] = 1'b1;
            flags_d[FLAG_WRITES_REG] = 1'b0;
         end
         OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU: lat_d = LAT_CLASS_MUL;
         OP_DIV, OP_DIVU, OP_REM, OP_REMU: lat_d = LAT_CLASS_DIV;
         OP_FLW: begin
            flags_d[FLAG_RV32F] = 1'b1;
            flags_d[FLAG_WRITES_REG] = 1'b0;
            flags_d[FLAG_WRITES_FREG] = 1'b1;
            flags_d[FLAG_IS_LOAD] = 1'b1;
            lat_d = LAT_CLASS_LOAD;
         end
         OP_FSW: begin
            flags_d[FLAG_RV32F] = 1'b1;
            flags_d[FLAG_WRITES_REG] = 1'b0;
            flags_d[FLAG_USES_FREG] = 1'b1;
            flags_d[FLAG_IS_STORE] = 1'b1;
            lat_d = LAT_CLASS_FP;
         end
         OP_FADD, OP_FSUB, OP_FMUL, OP_FDIV, OP_FSQRT, OP_FSGNJ, OP_FSGNJN, OP_FSGNJX: begin
            flags_d[FLAG_RV32F] = 1'b1;
            flags_d[FLAG_WRITES_REG] = 1'b0;
            flags_d[FLAG_WRITES_FREG] = 1'b1;
            flags_d[FLAG_USES_REG] = 1'b0;
            flags_d[FLAG_USES_FREG] = 1'b1;
            lat_d = LAT_CLASS_FP;
         end
         // fp sources, integer result
         OP_FCVTWS, OP_FMVXW, OP_FEQ, OP_FLE: begin
            flags_d[FLAG_RV32F] = 1'b1;
            flags_d[FLAG_USES_REG] = 1'b0;
            flags_d[FLAG_USES_FREG] = 1'b1;
            lat_d = LAT_CLASS_FP;
         end
         OP_FCVTSW, OP_FMVWX: begin
            flags_d[FLAG_RV32F] = 1'b1;
            flags_d[FLAG_WRITES_REG] = 1'b0;
            flags_d[FLAG_WRITES_FREG] = 1'b1;
            lat_d = LAT_CLASS_FP;
         end
         default: ;
      endcase
   end

   always_comb begin
      imm_d = '0;
      if (i_type)
         imm_d = {{20{instr_raw[31]}}, instr_raw[31:20]};
      else if (s_type)
         imm_d = {{20{instr_raw[31]}}, instr_raw[31:25], instr_raw[11:7]};
      else if (b_type)
         imm_d = {{19{instr_raw[31]}}, instr_raw[31], instr_raw[7], instr_raw[30:25],
                  instr_raw[11:8], 1'b0};
      else if (u_type)
         imm_d = {instr_raw[31:12], 12'b0};
      else if (j_type)
         imm_d = {{11{instr_raw[31]}}, instr_raw[31], instr_raw[19:12], instr_raw[20],
                  instr_raw[30:21], 1'b0};
   end

   always_ff @(posedge clk) begin
      if (rstn)
         done <= 1'b0;
      else if (enabled)
         done <= 1'b1;
   end

   always_ff @(posedge clk) begin
      if (enabled) begin
         op        <= op_d;
         flags     <= flags_d;
         lat_class <= lat_d;
         imm       <= imm_d;
         pc_out    <= pc;
         rd        <= (r_type || i_type || u_type || j_type) ? f_rd : '0;
         rs1       <= (r_type || i_type || s_type || b_type) ? f_rs1 : '0;
         rs2       <= (r_type || s_type || b_type) ? f_rs2 : '0;
      end
   end

   assign completed = done & ~enabled;

endmodule

`default_nettype wire

//--- rtl/issue_scoreboard.sv
`default_nettype none

module issue_scoreboard #(
   parameter rv_pkg::count_t LAT_LOAD = 4'd2,
   parameter rv_pkg::count_t LAT_MUL  = 4'd3,
   parameter rv_pkg::count_t LAT_DIV  = 4'd8,
   parameter rv_pkg::count_t LAT_FP   = 4'd4
) (
   input  wire                      clk,
   input  wire                      rstn,
   input  wire                      issue,
   input  wire rv_pkg::flags_t      flags,
   input  wire rv_pkg::reg_idx_t    rd,
   input  wire rv_pkg::reg_idx_t    rs1,
   input  wire rv_pkg::reg_idx_t    rs2,
   input  wire rv_pkg::lat_class_t  lat_class,
   output logic                     hazard
);
   import rv_pkg::*;

   localparam count_t LAT_ALU = 4'd1;

   count_t x_cnt [32];
   count_t f_cnt [32];
   count_t lat;
   logic   rs1_busy;
   logic   rs2_busy;
   logic   rd_busy;

   always_comb begin
      case (lat_class)
         LAT_CLASS_LOAD: lat = LAT_LOAD;
         LAT_CLASS_MUL:  lat = LAT_MUL;
         LAT_CLASS_DIV:  lat = LAT_DIV;
         LAT_CLASS_FP:   lat = LAT_FP;
         default:        lat = LAT_ALU;
      endcase
   end

   // with both uses flags set (fsw), rs1 is the integer base and rs2 the fp data
   always_comb begin
      rs1_busy = 1'b0;
      rs2_busy = 1'b0;
      rd_busy = 1'b0;
      if (flags[FLAG_USES_REG])
         rs1_busy = (x_cnt[rs1] != '0);
      else if (flags[FLAG_USES_FREG])
         rs1_busy = (f_cnt[rs1] != '0);
      if (rs2 != '0) begin
         if (flags[FLAG_USES_FREG])
            rs2_busy = (f_cnt[rs2] != '0);
         else if (flags[FLAG_USES_REG])
            rs2_busy = (x_cnt[rs2] != '0);
      end
      if (flags[FLAG_WRITES_FREG])
         rd_busy = (f_cnt[rd] != '0);
      else if (flags[FLAG_WRITES_REG])
         rd_busy = (x_cnt[rd] != '0);
   end

   assign hazard = rs1_busy | rs2_busy | rd_busy;

   always_ff @(posedge clk) begin
      if (rstn) begin
         for (int i = 0; i < 32; i++) begin
            x_cnt[i] <= '0;
            f_cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < 32; i++) begin
            if (x_cnt[i] != '0)
               x_cnt[i] <= x_cnt[i] - 1'b1;
            if (f_cnt[i] != '0)
               f_cnt[i] <= f_cnt[i] - 1'b1;
         end
         // destination load overrides the decrement, x0 stays free
         if (issue && flags[FLAG_WRITES_FREG])
            f_cnt[rd] <= lat;
         else if (issue && flags[FLAG_WRITES_REG] && (rd != '0))
            x_cnt[rd] <= lat;
      end
   end

endmodule

`default_nettype wire

//--- rtl/decode_ctrl.sv
`default_nettype none

module decode_ctrl (
   input  wire  clk,
   input  wire  rstn,
   input  wire  in_valid,
   input  wire  completed,
   input  wire  hazard,
   output logic ready,
   output logic enabled,
   output logic issue_valid
);
   import rv_pkg::*;

   ctrl_state_t state;
   ctrl_state_t state_nx;

   assign ready = (state == S_IDLE);
   assign enabled = ready & in_valid;

   // decoded fields are valid once the decoder reports completion
   assign issue_valid = (state == S_CHECK) & completed & ~hazard;

   always_comb begin
      state_nx = state;
      case (state)
         S_IDLE: begin
            if (enabled)
               state_nx = S_CHECK;
         end
         S_CHECK: begin
            // hold here while stalled
            if (issue_valid)
               state_nx = S_IDLE;
         end
         default: state_nx = S_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rstn)
         state <= S_IDLE;
      else
         state <= state_nx;
   end

endmodule

`default_nettype wire

//--- rtl/decode_unit.sv
`default_nettype none

module decode_unit #(
   parameter rv_pkg::count_t LAT_LOAD = 4'd2,
   parameter rv_pkg::count_t LAT_MUL  = 4'd3,
   parameter rv_pkg::count_t LAT_DIV  = 4'd8,
   parameter rv_pkg::count_t LAT_FP   = 4'd4
) (
   input  wire                    clk,
   input  wire                    rstn,
   input  wire                    in_valid,
   input  wire rv_pkg::word_t     instr_raw,
   input  wire rv_pkg::word_t     pc,
   input  wire                    is_jump_predicted,
   output logic                   ready,
   output logic                   issue_valid,
   output rv_pkg::op_t            issue_op,
   output rv_pkg::flags_t         issue_flags,
   output rv_pkg::reg_idx_t       issue_rd,
   output rv_pkg::reg_idx_t       issue_rs1,
   output rv_pkg::reg_idx_t       issue_rs2,
   output rv_pkg::word_t          issue_imm,
   output rv_pkg::word_t          issue_pc
);
   import rv_pkg::*;

   logic       enabled;
   logic       completed;
   logic       hazard;
   lat_class_t lat_class;

   decode_ctrl ctrl_i (
      .clk         (clk),
      .rstn        (rstn),
      .in_valid    (in_valid),
      .completed   (completed),
      .hazard      (hazard),
      .ready       (ready),
      .enabled     (enabled),
      .issue_valid (issue_valid)
   );

   rv_decoder decoder_i (
      .clk               (clk),
      .rstn              (rstn),
      .enabled           (enabled),
      .instr_raw         (instr_raw),
      .pc                (pc),
      .is_jump_predicted (is_jump_predicted),
      .completed         (completed),
      .op                (issue_op),
      .flags             (issue_flags),
      .rd                (issue_rd),
      .rs1               (issue_rs1),
      .rs2               (issue_rs2),
      .imm               (issue_imm),
      .pc_out            (issue_pc),
      .lat_class         (lat_class)
   );

   issue_scoreboard #(
      .LAT_LOAD (LAT_LOAD),
      .LAT_MUL  (LAT_MUL),
      .LAT_DIV  (LAT_DIV),
      .LAT_FP   (LAT_FP)
   ) scoreboard_i (
      .clk       (clk),
      .rstn      (rstn),
      .issue     (issue_valid),
      .flags     (issue_flags),
      .rd        (issue_rd),
      .rs1       (issue_rs1),
      .rs2       (issue_rs2),
      .lat_class (lat_class),
      .hazard    (hazard)
   );

endmodule

`default_nettype wire

//--- verif/decode_unit_asserts.sv
`default_nettype none

module decode_unit_asserts (
   input wire clk,
   input wire rstn,
   input wire ready,
   input wire enabled,
   input wire issue_valid,
   input wire hazard
);

   issue_not_ready: assert property (@(posedge clk) disable iff (rstn)
      !(issue_valid && ready))
      else $error("issue_valid and ready were high in the same cycle");

   enabled_ready: assert property (@(posedge clk) disable iff (rstn)
      enabled |-> ready)
      else $error("decoder enabled while ready was low");

   // single-cycle issue strobe
   issue_one_cycle: assert property (@(posedge clk) disable iff (rstn)
      issue_valid |=> !issue_valid)
      else $error("issue_valid stayed high for more than one cycle");

   issue_no_hazard: assert property (@(posedge clk) disable iff (rstn)
      !(issue_valid && hazard))
      else $error("issue_valid high while hazard was high");

endmodule

bind decode_ctrl decode_unit_asserts asserts_i (
   .clk         (clk),
   .rstn        (rstn),
   .ready       (ready),
   .enabled     (enabled),
   .issue_valid (issue_valid),
   .hazard      (hazard)
);

`default_nettype wire

//--- verif/tb_decode_unit.sv
`default_nettype none

module tb_decode_unit;
   import rv_pkg::*;

   localparam count_t lat_load = 4'd2;
   localparam count_t lat_mul = 4'd3;
   localparam count_t lat_div = 4'd8;
   localparam count_t lat_fp = 4'd4;
   localparam int num_instr = 400;

   // match values per op id, index 0 is the illegal id
   localparam word_t enc_match [0:61] = '{
      32'h00000000, 32'h00000037, 32'h00000017, 32'h0000006f, 32'h00000067,
      32'h00000063, 32'h00001063, 32'h00004063, 32'h00005063, 32'h00006063, 32'h00007063,
      32'h00000003, 32'h00001003, 32'h00002003, 32'h00004003, 32'h00005003,
      32'h00000023, 32'h00001023, 32'h00002023,
      32'h00000013, 32'h00002013, 32'h00003013, 32'h00004013, 32'h00006013, 32'h00007013,
      32'h00001013, 32'h00005013, 32'h40005013,
      32'h00000033, 32'h40000033, 32'h00001033, 32'h00002033, 32'h00003033,
      32'h00004033, 32'h00005033, 32'h40005033, 32'h00006033, 32'h00007033,
      32'h02000033, 32'h02001033, 32'h02002033, 32'h02003033,
      32'h02004033, 32'h02005033, 32'h02006033, 32'h02007033,
      32'h00002007, 32'h00002027,
      32'h00000053, 32'h08000053, 32'h10000053, 32'h18000053, 32'h58000053,
      32'h20000053, 32'h20001053, 32'h20002053, 32'hc0000053, 32'he0000053,
      32'ha0002053, 32'ha0000053, 32'hd0000053, 32'hf0000053
   };

   logic       clk;
   logic       rstn;
   logic       in_valid;
   word_t      instr_raw;
   word_t      pc;
   logic       is_jump_predicted;
   logic       ready;
   logic       issue_valid;
   op_t        issue_op;
   flags_t     issue_flags;
   reg_idx_t   issue_rd;
   reg_idx_t   issue_rs1;
   reg_idx_t   issue_rs2;
   word_t      issue_imm;
   word_t      issue_pc;

   // reference model state
   count_t     xc [32];
   count_t     fc [32];
   logic       pending;
   logic       exp_issue;
   op_t        exp_op;
   flags_t     exp_flags;
   reg_idx_t   exp_rd;
   reg_idx_t   exp_rs1;
   reg_idx_t   exp_rs2;
   word_t      exp_imm;
   word_t      exp_pc;
   count_t     exp_lat;
   int         r;
   int         n;
   int         issued;
   int         errors;
   int         checks;
   logic       timed_out;

   decode_unit #(
      .LAT_LOAD (lat_load),
      .LAT_MUL  (lat_mul),
      .LAT_DIV  (lat_div),
      .LAT_FP   (lat_fp)
   ) dut_i (
      .clk               (clk),
      .rstn              (rstn),
      .in_valid          (in_valid),
      .instr_raw         (instr_raw),
      .pc                (pc),
      .is_jump_predicted (is_jump_predicted),
      .ready             (ready),
      .issue_valid       (issue_valid),
      .issue_op          (issue_op),
      .issue_flags       (issue_flags),
      .issue_rd          (issue_rd),
      .issue_rs1         (issue_rs1),
      .issue_rs2         (issue_rs2),
      .issue_imm         (issue_imm),
      .issue_pc          (issue_pc)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic check_word(input string name, input word_t exp, input word_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Fail %s (instr %0d): expected %h, actual %h", name, issued, exp, act);
      end
   endtask

   task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Fail %s (instr %0d): expected %0d, actual %0d", name, issued, exp, act);
      end
   endtask

   task automatic check_op(input string name, input op_t exp, input op_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Fail %s (instr %0d): expected %0d, actual %0d", name, issued, exp, act);
      end
   endtask

   task automatic check_flags(input string name, input flags_t exp, input flags_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Fail %s (instr %0d): expected %b, actual %b", name, issued, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Fail %s (instr %0d): expected %b, actual %b", name, issued, exp, act);
      end
   endtask

   function automatic word_t enc_mask(input op_t o);
      if (o <= OP_JALR)
         return 32'h0000007f;
      // unary fp ops also fix rs2 to zero
      if (o == OP_FSQRT || o == OP_FCVTWS || o == OP_FMVXW || o >= OP_FCVTSW)
         return 32'hfff0707f;
      if ((o >= OP_SRLI && o <= OP_REMU) || o >= OP_FADD)
         return 32'hfe00707f;
      return 32'h0000707f;
   endfunction

   function automatic flags_t flags_of(input op_t o, input logic pred);
      flags_t f;
      f = '0;
      f[FLAG_JUMP_PREDICTED] = pred;
      if (o == OP_ILLEGAL)
         return f;
      if (o < OP_FLW) begin
         f[FLAG_USES_REG] = 1'b1;
         f[FLAG_IS_COND_JUMP] = (o >= OP_BEQ && o <= OP_BGEU);
         f[FLAG_IS_LOAD] = (o >= OP_LB && o <= OP_LHU);
         f[FLAG_IS_STORE] = (o >= OP_SB && o <= OP_SW);
         f[FLAG_WRITES_REG] = !f[FLAG_IS_COND_JUMP] && !f[FLAG_IS_STORE];
         return f;
      end
      f[FLAG_RV32F] = 1'b1;
      f[FLAG_IS_LOAD] = (o == OP_FLW);
      f[FLAG_IS_STORE] = (o == OP_FSW);
      // integer sources for flw, fsw base, fcvt.s.w and fmv.w.x
      f[FLAG_USES_REG] = (o <= OP_FSW) || (o >= OP_FCVTSW);
      f[FLAG_USES_FREG] = (o >= OP_FSW) && (o < OP_FCVTSW);
      f[FLAG_WRITES_REG] = (o >= OP_FCVTWS) && (o <= OP_FLE);
      f[FLAG_WRITES_FREG] = (o == OP_FLW) || (o >= OP_FADD && o <= OP_FSGNJX)
                         || (o >= OP_FCVTSW);
      return f;
   endfunction

   function automatic count_t lat_of(input op_t o);
      if ((o >= OP_LB && o <= OP_LHU) || o == OP_FLW)
         return lat_load;
      if (o >= OP_MUL && o <= OP_MULHU)
         return lat_mul;
      if (o >= OP_DIV && o <= OP_REMU)
         return lat_div;
      if (o >= OP_FSW)
         return lat_fp;
      return 4'd1;
   endfunction

   function automatic word_t sext(input word_t v, input int bits);
      word_t s;
      s = v << (32 - bits);
      return word_t'($signed(s) >>> (32 - bits));
   endfunction

   task automatic decode_model(input word_t w, input logic pred);
      logic [6:0] opc;
      logic       fr;
      logic       fi;
      logic       fs;
      logic       fb;
      logic       fu;
      logic       fj;
      int         k;
      opc = w[6:0];
      fr = (opc == 7'h33) || (opc == 7'h53);
      fi = (opc == 7'h67) || (opc == 7'h03) || (opc == 7'h13) || (opc == 7'h07);
      fs = (opc == 7'h23) || (opc == 7'h27);
      fb = (opc == 7'h63);
      fu = (opc == 7'h37) || (opc == 7'h17);
      fj = (opc == 7'h6f);
      exp_op = OP_ILLEGAL;
      for (k = 61; k >= 1; k--) begin
         if ((w & enc_mask(op_t'(k))) == enc_match[k])
            exp_op = op_t'(k);
      end
      exp_flags = flags_of(exp_op, pred);
      exp_lat = lat_of(exp_op);
      exp_rd = (fr || fi || fu || fj) ? w[11:7] : '0;
      exp_rs1 = (fr || fi || fs || fb) ? w[19:15] : '0;
      exp_rs2 = (fr || fs || fb) ? w[24:20] : '0;
      if (fi)
         exp_imm = sext({20'd0, w[31:20]}, 12);
      else if (fs)
         exp_imm = sext({20'd0, w[31:25], w[11:7]}, 12);
      else if (fb)
         exp_imm = sext({19'd0, w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
      else if (fu)
         exp_imm = {w[31:12], 12'd0};
      else if (fj)
         exp_imm = sext({11'd0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
      else
         exp_imm = '0;
   endtask

   function automatic logic model_hazard(input flags_t f, input reg_idx_t d,
                                         input reg_idx_t s1, input reg_idx_t s2);
      logic h;
      h = 1'b0;
      if (f[FLAG_USES_REG])
         h = h | (xc[s1] != '0);
      else if (f[FLAG_USES_FREG])
         h = h | (fc[s1] != '0);
      if (s2 != '0) begin
         if (f[FLAG_USES_FREG])
            h = h | (fc[s2] != '0);
         else if (f[FLAG_USES_REG])
            h = h | (xc[s2] != '0);
      end
      if (f[FLAG_WRITES_FREG])
         h = h | (fc[d] != '0);
      else if (f[FLAG_WRITES_REG])
         h = h | (xc[d] != '0);
      return h;
   endfunction

   function automatic word_t make_instr();
      word_t w;
      op_t   k;
      w = $urandom;
      // raw word, half of them with a known opcode
      if ($urandom_range(9, 0) == 0) begin
         if ($urandom_range(1, 0) == 1)
            w[6:0] = enc_match[$urandom_range(61, 1)][6:0];
         return w;
      end
      k = op_t'($urandom_range(61, 1));
      // few registers so dependencies are common
      if ($urandom_range(3, 0) != 0) begin
         w[11:7] = 5'($urandom_range(3, 0));
         w[19:15] = 5'($urandom_range(3, 0));
         w[24:20] = 5'($urandom_range(3, 0));
      end
      return (w & ~enc_mask(k)) | enc_match[k];
   endfunction

   // model runs mid-cycle, where DUT outputs and TB inputs are stable
   always @(negedge clk) begin
      if (rstn) begin
         for (r = 0; r < 32; r++) begin
            xc[r] = '0;
            fc[r] = '0;
         end
         pending = 1'b0;
      end else begin
         exp_issue = pending && !model_hazard(exp_flags, exp_rd, exp_rs1, exp_rs2);
         check_bit("ready", !pending, ready);
         check_bit("issue_valid", exp_issue, issue_valid);
         if (exp_issue && issue_valid) begin
            check_op("issue_op", exp_op, issue_op);
            check_flags("issue_flags", exp_flags, issue_flags);
            check_reg("issue_rd", exp_rd, issue_rd);
            check_reg("issue_rs1", exp_rs1, issue_rs1);
            check_reg("issue_rs2", exp_rs2, issue_rs2);
            check_word("issue_imm", exp_imm, issue_imm);
            check_word("issue_pc", exp_pc, issue_pc);
         end
         // countdown update for the coming edge
         for (r = 0; r < 32; r++) begin
            if (xc[r] != '0)
               xc[r] = xc[r] - 4'd1;
            if (fc[r] != '0)
               fc[r] = fc[r] - 4'd1;
         end
         if (exp_issue) begin
            if (exp_flags[FLAG_WRITES_FREG])
               fc[exp_rd] = exp_lat;
            else if (exp_flags[FLAG_WRITES_REG] && exp_rd != '0)
               xc[exp_rd] = exp_lat;
            pending = 1'b0;
            issued++;
         end else if (!pending && in_valid) begin
            decode_model(instr_raw, is_jump_predicted);
            exp_pc = pc;
            pending = 1'b1;
         end
      end
   end

   task automatic wait_for_ready(input int limit);
      int t;
      t = 0;
      @(negedge clk);
      while (!ready && t < limit) begin
         @(negedge clk);
         t++;
      end
      if (!ready) begin
         timed_out = 1'b1;
         $display("timeout: ready did not come back within %0d cycles", limit);
      end
   endtask

   initial begin
      int gap;
      void'($urandom(67));
      errors = 0;
      checks = 0;
      issued = 0;
      timed_out = 1'b0;
      rstn <= 1'b1;
      in_valid <= 1'b0;
      instr_raw <= '0;
      pc <= '0;
      is_jump_predicted <= 1'b0;
      repeat (10) @(posedge clk);
      rstn <= 1'b0;
      for (n = 0; n < num_instr && !timed_out; n++) begin
         gap = $urandom_range(3, 0);
         repeat (gap) @(posedge clk);
         in_valid <= 1'b1;
         instr_raw <= make_instr();
         pc <= $urandom;
         is_jump_predicted <= 1'($urandom_range(1, 0));
         wait_for_ready(50);
         @(posedge clk);
         in_valid <= 1'b0;
      end
      if (!timed_out)
         wait_for_ready(50);
      repeat (4) @(posedge clk);
      $display("errors: %0d, checks: %0d, issued: %0d", errors, checks, issued);
      if (errors == 0 && !timed_out)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/issue_scoreboard.sv
rtl/decode_ctrl.sv
rtl/decode_unit.sv
verif/decode_unit_asserts.sv
verif/tb_decode_unit.sv

//--- Makefile
TOP = tb_decode_unit

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f --Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir
